// File: list.f
verilog/mem_msg_pkg.sv
verilog/mem_port_if.sv
verilog/msg_fifo.sv
verilog/interval_timer.sv
verilog/mem_server_ctrl.sv
verilog/mem_array.sv
verilog/mem_server.sv
tests/mem_server_tb.sv

// File: tests/mem_server_tb.sv
//----------------------------------------
// Memory server testbench
// Directed tests checked against a byte
// reference memory with written flags
//----------------------------------------

`timescale 1ns/1ps

module mem_server_tb;

  import mem_msg_pkg::*;

  localparam int mem_words  = 256;
  localparam int fifo_depth = 4;
  localparam int req_gap    = 1;
  localparam int resp_gap   = 1;
  // Cycles any single wait may take
  localparam int wait_limit = 200;

  logic                     clk, rst;
  logic                     req_val, req_rdy, resp_val, resp_rdy;
  mem_op_e                  req_op, resp_op;
  logic [mem_opaq_bits-1:0] req_opaque, resp_opaque;
  logic [mem_addr_bits-1:0] req_addr, resp_addr;
  logic [mem_len_bits-1:0]  req_len, resp_len;
  logic [mem_data_bits-1:0] req_data, resp_data;

  // Reference memory, four bytes per word
  logic [7:0]  ref_bytes [4*mem_words];
  logic        ref_written [mem_words];
  // Expected responses in request order
  mem_resp_t   exp_q [$];
  logic [31:0] lfsr;
  // Posedge count and last transfer edges
  int          cyc = 0;
  int          errors, checks, tests, last_req, last_resp;
  bit          hung;

  mem_server #(
    .p_mem_words(mem_words), .p_fifo_depth(fifo_depth),
    .p_req_intv_delay(req_gap), .p_resp_intv_delay(resp_gap)
  ) i_dut (
    .clk(clk), .rst(rst),
    .req_val(req_val), .req_rdy(req_rdy), .req_op(req_op), .req_opaque(req_opaque),
    .req_addr(req_addr), .req_len(req_len), .req_data(req_data),
    .resp_val(resp_val), .resp_rdy(resp_rdy), .resp_op(resp_op), .resp_opaque(resp_opaque),
    .resp_addr(resp_addr), .resp_len(resp_len), .resp_data(resp_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  //----------------------------------------
  // Stimulus and reference model
  //----------------------------------------

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // Expected response; writes update the reference
  function automatic mem_resp_t model_access(logic [1:0] op, logic [7:0] tag,
                                             logic [15:0] addr, logic [1:0] len,
                                             logic [31:0] data);
    mem_resp_t r;
    int        w;
    int        lanes;
    w     = (addr >> 2) % mem_words;
    lanes = (len == 2'd0) ? 4 : int'(len);
    r     = {op, tag, addr, len, 32'h0};
    if (op == 2'd1) begin
      // First write clears the skipped lanes
      for (int b = 0; b < 4; b++)
        if (!ref_written[w] || b < lanes)
          ref_bytes[4*w+b] = (b < lanes) ? data[8*b +: 8] : 8'h00;
      ref_written[w] = 1'b1;
    end else if (op == 2'd0 && ref_written[w]) begin
      for (int b = 0; b < lanes; b++)
        r.data[8*b +: 8] = ref_bytes[4*w+b];
    end
    return r;
  endfunction

  task automatic note_timeout(string what);
    errors++;
    hung = 1'b1;
    $display("Timed out after %0d cycles waiting for %s", wait_limit, what);
  endtask

  //----------------------------------------
  // Compare tasks
  //----------------------------------------

  task automatic check_bit(logic exp, logic got, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_gap(int lo, int hi, int got, string what);
    checks++;
    if (got < lo || got > hi) begin
      errors++;
      $display("FAIL %0t: %s %0d cycles, expected %0d to %0d", $time, what, got, lo, hi);
    end
  endtask

  task automatic check_resp(mem_resp_t exp, mem_resp_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: response op %0d tag %h addr %h len %0d data %h, expected %0d %h %h %0d %h",
               $time, got.op, got.opaque, got.addr, got.len, got.data,
               exp.op, exp.opaque, exp.addr, exp.len, exp.data);
    end
  endtask

  //----------------------------------------
  // Stream drivers, entered and left at negedge
  //----------------------------------------

  task automatic send_req(logic [1:0] op, logic [7:0] tag, logic [15:0] addr,
                          logic [1:0] len, logic [31:0] data);
    int n;
    n          = 0;
    req_val    = 1'b1;
    req_op     = mem_op_e'(op);
    req_opaque = tag;
    req_addr   = addr;
    req_len    = len;
    req_data   = data;
    while (!req_rdy && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!req_rdy) begin
      note_timeout("req_rdy");
    end else begin
      // Transfer lands on the coming posedge
      if (last_req >= 0)
        check_gap(req_gap + 1, 1 << 30, cyc + 1 - last_req, "request spacing");
      last_req = cyc + 1;
      exp_q.push_back(model_access(op, tag, addr, len, data));
      @(negedge clk);
    end
    req_val = 1'b0;
  endtask

  // Assumes resp_rdy high; at gives the transfer edge
  task automatic take_resp(output int at);
    mem_resp_t got;
    int        n;
    n  = 0;
    at = -1;
    while (!resp_val && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!resp_val) begin
      note_timeout("resp_val");
    end else begin
      got = {resp_op, resp_opaque, resp_addr, resp_len, resp_data};
      check_resp(exp_q.pop_front(), got);
      if (last_resp >= 0)
        check_gap(resp_gap + 1, 1 << 30, cyc + 1 - last_resp, "response spacing");
      last_resp = cyc + 1;
      at        = cyc + 1;
      @(negedge clk);
    end
  endtask

  task automatic transact(logic [1:0] op, logic [7:0] tag, logic [15:0] addr,
                          logic [1:0] len, logic [31:0] data);
    int at;
    send_req(op, tag, addr, len, data);
    take_resp(at);
  endtask

  task automatic end_test(string name, int err_before);
    tests++;
    $display("Test %s: %s", name, (errors == err_before) ? "passed" : "failed");
  endtask

  //----------------------------------------
  // Directed tests
  //----------------------------------------

  task automatic test_reset_rw();
    int e;
    e = errors;
    check_bit(1'b0, resp_val, "resp_val after reset");
    check_bit(1'b1, req_rdy, "req_rdy after reset");
    transact(2'd1, 8'h11, 16'h0040, 2'd0, 32'hcafe_f00d);
    transact(2'd0, 8'h12, 16'h0040, 2'd0, '0);
    end_test("reset_rw", e);
  endtask

  task automatic test_lengths();
    int e;
    e = errors;
    // Unwritten word, then a partial first write
    transact(2'd0, 8'h20, 16'h0200, 2'd0, '0);
    transact(2'd1, 8'h21, 16'h0200, 2'd2, 32'h1234_5678);
    transact(2'd0, 8'h22, 16'h0200, 2'd0, '0);
    // Unaligned address hits the same word
    for (int l = 1; l < 4; l++) begin
      transact(2'd1, 8'h23, 16'h0084, 2'd0, 32'ha1b2_c3d4);
      transact(2'd1, 8'h24, 16'h0086, 2'(l), 32'h5566_7788);
      transact(2'd0, 8'h25, 16'h0084, 2'd0, '0);
      transact(2'd0, 8'h26, 16'h0084, 2'(l), '0);
    end
    end_test("lengths", e);
  endtask

  task automatic test_undef_op();
    int e;
    e = errors;
    transact(2'd1, 8'h30, 16'h0100, 2'd0, 32'h0bad_beef);
    transact(2'd2, 8'h31, 16'h0100, 2'd0, 32'hffff_ffff);
    transact(2'd3, 8'h32, 16'h0100, 2'd1, 32'h0000_0000);
    transact(2'd0, 8'h33, 16'h0100, 2'd0, '0);
    end_test("undef_op", e);
  endtask

  task automatic test_random();
    int          e, at;
    logic [1:0]  op, len;
    logic [15:0] addr;
    e = errors;
    // Upper address bits alias onto sixteen words
    fork
      for (int k = 0; k < 40; k++) begin
        op   = 2'(rand_bits(1));
        addr = {6'(rand_bits(6)), 4'b0100, 4'(rand_bits(4)), 2'(rand_bits(2))};
        len  = 2'(rand_bits(2));
        send_req(op, 8'(k), addr, len, rand_bits(32));
      end
      for (int k = 0; k < 40; k++)
        take_resp(at);
    join
    end_test("random", e);
  endtask

  task automatic test_backpressure();
    int e, sent, idle, at;
    e        = errors;
    sent     = 0;
    idle     = 0;
    resp_rdy = 1'b0;
    // Fill both queues until requests stall
    while (idle < 12 && sent < 4 * fifo_depth) begin
      if (req_rdy) begin
        send_req(2'd1, 8'(8'h50 + sent), 16'(4 * sent), 2'd0, rand_bits(32));
        sent++;
        idle = 0;
      end else begin
        @(negedge clk);
        idle++;
      end
    end
    check_bit(1'b0, req_rdy, "req_rdy under back-pressure");
    check_bit(1'b1, resp_val, "resp_val under back-pressure");
    resp_rdy = 1'b1;
    repeat (sent) take_resp(at);
    end_test("backpressure", e);
  endtask

  task automatic test_timing();
    int e, at, req_at;
    e = errors;
    // Isolated read on an idle server
    repeat (4) @(negedge clk);
    send_req(2'd0, 8'h60, 16'h0040, 2'd0, '0);
    req_at = last_req;
    take_resp(at);
    check_gap(3, 3, at - req_at, "request to response latency");
    // Burst, spacing checked on each transfer
    fork
      for (int k = 0; k < 8; k++)
        send_req(2'd1, 8'(8'h70 + k), 16'(8 * k), 2'(k), rand_bits(32));
      for (int k = 0; k < 8; k++)
        take_resp(at);
    join
    end_test("timing", e);
  endtask

  initial begin
    rst        = 1'b1;
    req_val    = 1'b0;
    req_op     = mem_op_read;
    req_opaque = '0;
    req_addr   = '0;
    req_len    = '0;
    req_data   = '0;
    resp_rdy   = 1'b1;
    lfsr       = 32'h9d50_c3bf;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    last_req   = -1;
    last_resp  = -1;
    hung       = 1'b0;
    foreach (ref_written[i])
      ref_written[i] = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (!hung) test_reset_rw();
    if (!hung) test_lengths();
    if (!hung) test_undef_op();
    if (!hung) test_random();
    if (!hung) test_backpressure();
    if (!hung) test_timing();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: verilog/interval_timer.sv
//----------------------------------------
// Interval timer
// Holds busy for p_delay cycles after each
// transfer to space a stream out
//----------------------------------------

`timescale 1ns/1ps

module interval_timer #(
  parameter int p_delay = 1
)(
  input  logic clk,
  input  logic rst,

  // One cycle pulse per stream transfer
  input  logic start,
  output logic busy
);

  // Counter wide enough for p_delay, never zero width
  localparam int cnt_bits = (p_delay > 0) ? $clog2(p_delay + 1) : 1;

  logic [cnt_bits-1:0] count;

  //----------------------------------------
  // Down-counter
  //----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (start) begin
      // Reload, p_delay 0 leaves it idle
      count <= cnt_bits'(p_delay);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign busy = (count != '0);

  // Stream gating keeps transfers out of the busy window
  a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
    else $error("interval_timer: transfer while busy");

endmodule

// File: verilog/mem_array.sv
//----------------------------------------
// Word array
// Length-masked reads and writes, with a
// written flag per word
//----------------------------------------

`timescale 1ns/1ps

module mem_array #(
  parameter int p_words = 256
)(
  input  logic      clk,
  input  logic      rst,
  mem_port_if.array port
);

  import mem_msg_pkg::*;

  localparam int idx_bits = (p_words > 1) ? $clog2(p_words) : 1;
  localparam int n_bytes  = mem_data_bits / 8;

  logic [mem_data_bits-1:0] words [p_words];
  logic [p_words-1:0]       written;
  logic [idx_bits-1:0]      word_idx;
  logic [n_bytes-1:0]       byte_mask;
  logic [n_bytes-1:0]       byte_we;
  logic [mem_data_bits-1:0] lane_mask;
  logic [mem_data_bits-1:0] wr_word;

  // Byte address to word index, wraps at p_words
  assign word_idx = idx_bits'((port.addr >> 2) % p_words);

  //----------------------------------------
  // Byte lanes
  //----------------------------------------

  always_comb begin
    // len 0 is the full word
    if (port.len == '0)
      byte_mask = '1;
    else
      byte_mask = n_bytes'((1 << port.len) - 1);
    for (int b = 0; b < n_bytes; b++) begin
      lane_mask[8*b +: 8] = {8{byte_mask[b]}};
      // First write to a word zeroes the skipped lanes
      byte_we[b] = port.en && port.we && (byte_mask[b] || !written[word_idx]);
      wr_word[8*b +: 8] = byte_mask[b] ? port.wdata[8*b +: 8] : 8'h00;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    for (int b = 0; b < n_bytes; b++) begin
      if (byte_we[b])
        words[word_idx][8*b +: 8] <= wr_word[8*b +: 8];
    end
  end

  // Written flags
  always_ff @(posedge clk) begin
    if (rst)
      written <= '0;
    else if (port.en && port.we)
      written[word_idx] <= 1'b1;
  end

  // Registered read, unwritten words read as zero
  always_ff @(posedge clk) begin
    if (port.en && !port.we)
      port.rdata <= written[word_idx] ? (words[word_idx] & lane_mask) : '0;
  end

endmodule

// File: verilog/mem_msg_pkg.sv
//----------------------------------------
// Memory message package
// Field widths, op codes and the request
// and response structs of the server
//----------------------------------------

package mem_msg_pkg;

  //----------------------------------------
  // Field widths
  //----------------------------------------

  // Byte address
  parameter int mem_addr_bits = 16;
  // Word data
  parameter int mem_data_bits = 32;
  // Opaque tag, echoed untouched
  parameter int mem_opaq_bits = 8;
  // Length, 0 means the full word
  parameter int mem_len_bits  = 2;

  //----------------------------------------
  // Op codes
  //----------------------------------------

  // Values 2 and 3 are undefined ops
  typedef enum logic [1:0] {
    mem_op_read  = 2'd0,
    mem_op_write = 2'd1
  } mem_op_e;

  //----------------------------------------
  // Messages, 60 bits each
  //----------------------------------------

  typedef struct packed {
    mem_op_e                    op;
    logic [mem_opaq_bits-1:0]   opaque;
    logic [mem_addr_bits-1:0]   addr;
    logic [mem_len_bits-1:0]    len;
    logic [mem_data_bits-1:0]   data;
  } mem_req_t;

  // Same layout, data holds the read result
  typedef struct packed {
    mem_op_e                    op;
    logic [mem_opaq_bits-1:0]   opaque;
    logic [mem_addr_bits-1:0]   addr;
    logic [mem_len_bits-1:0]    len;
    logic [mem_data_bits-1:0]   data;
  } mem_resp_t;

endpackage

// File: verilog/mem_port_if.sv
//----------------------------------------
// Word array port
// Access strobe, address, length and data
// between control and the word array
//----------------------------------------

`timescale 1ns/1ps

interface mem_port_if;

  import mem_msg_pkg::*;

  // Access strobe and write select
  logic                       en;
  logic                       we;
  // Byte address and length of the access
  logic [mem_addr_bits-1:0]   addr;
  logic [mem_len_bits-1:0]    len;
  // Write data in, read data out
  logic [mem_data_bits-1:0]   wdata;
  // Valid the cycle after an en cycle
  logic [mem_data_bits-1:0]   rdata;

  // Control side
  modport ctrl (output en, we, addr, len, wdata, input rdata);

  // Array side
  modport array (input en, we, addr, len, wdata, output rdata);

endinterface

// File: verilog/mem_server.sv
//----------------------------------------
// Memory server top
// Request and response streams around the
// queues, timers, control and word array
//----------------------------------------

`timescale 1ns/1ps

module mem_server #(
  parameter int p_mem_words       = 256,
  parameter int p_fifo_depth      = 4,
  parameter int p_req_intv_delay  = 1,
  parameter int p_resp_intv_delay = 1
)(
  input  logic                                  clk,
  input  logic                                  rst,

  // Request stream
  input  logic                                  req_val,
  output logic                                  req_rdy,
  input  mem_msg_pkg::mem_op_e                  req_op,
  input  logic [mem_msg_pkg::mem_opaq_bits-1:0] req_opaque,
  input  logic [mem_msg_pkg::mem_addr_bits-1:0] req_addr,
  input  logic [mem_msg_pkg::mem_len_bits-1:0]  req_len,
  input  logic [mem_msg_pkg::mem_data_bits-1:0] req_data,

  // Response stream
  output logic                                  resp_val,
  input  logic                                  resp_rdy,
  output mem_msg_pkg::mem_op_e                  resp_op,
  output logic [mem_msg_pkg::mem_opaq_bits-1:0] resp_opaque,
  output logic [mem_msg_pkg::mem_addr_bits-1:0] resp_addr,
  output logic [mem_msg_pkg::mem_len_bits-1:0]  resp_len,
  output logic [mem_msg_pkg::mem_data_bits-1:0] resp_data
);

  import mem_msg_pkg::*;

  mem_req_t  req_in_msg;
  mem_req_t  req_head_msg;
  mem_resp_t resp_push_msg;
  mem_resp_t resp_head_msg;
  logic      req_xfer, resp_xfer;
  logic      req_full, req_empty, req_pop, req_busy;
  logic      resp_full, resp_empty, resp_push, resp_busy;

  mem_port_if i_mem_port ();

  //----------------------------------------
  // Stream handshakes
  //----------------------------------------

  assign req_rdy   = !req_full && !req_busy;
  assign resp_val  = !resp_empty && !resp_busy;
  assign req_xfer  = req_val && req_rdy;
  assign resp_xfer = resp_val && resp_rdy;

  // Pack request ports
  assign req_in_msg.op     = req_op;
  assign req_in_msg.opaque = req_opaque;
  assign req_in_msg.addr   = req_addr;
  assign req_in_msg.len    = req_len;
  assign req_in_msg.data   = req_data;

  // Unpack response head
  assign resp_op     = resp_head_msg.op;
  assign resp_opaque = resp_head_msg.opaque;
  assign resp_addr   = resp_head_msg.addr;
  assign resp_len    = resp_head_msg.len;
  assign resp_data   = resp_head_msg.data;

  //----------------------------------------
  // Instances
  //----------------------------------------

  msg_fifo #(.t_msg(mem_req_t), .p_depth(p_fifo_depth)) i_req_fifo (
    .clk(clk), .rst(rst), .push(req_xfer), .push_msg(req_in_msg), .pop(req_pop),
    .full(req_full), .empty(req_empty), .head_msg(req_head_msg)
  );

  msg_fifo #(.t_msg(mem_resp_t), .p_depth(p_fifo_depth)) i_resp_fifo (
    .clk(clk), .rst(rst), .push(resp_push), .push_msg(resp_push_msg), .pop(resp_xfer),
    .full(resp_full), .empty(resp_empty), .head_msg(resp_head_msg)
  );

  interval_timer #(.p_delay(p_req_intv_delay)) i_req_timer (
    .clk(clk), .rst(rst), .start(req_xfer), .busy(req_busy)
  );

  interval_timer #(.p_delay(p_resp_intv_delay)) i_resp_timer (
    .clk(clk), .rst(rst), .start(resp_xfer), .busy(resp_busy)
  );

  mem_server_ctrl i_ctrl (
    .clk(clk), .rst(rst),
    .req_empty(req_empty), .req_msg(req_head_msg), .req_pop(req_pop),
    .resp_full(resp_full), .resp_push(resp_push), .resp_msg(resp_push_msg),
    .mem(i_mem_port.ctrl)
  );

  mem_array #(.p_words(p_mem_words)) i_array (
    .clk(clk), .rst(rst), .port(i_mem_port.array)
  );

endmodule

// File: verilog/mem_server_ctrl.sv
//----------------------------------------
// Memory server control
// Two-state FSM, pops a request, runs the
// array access and pushes the response
//----------------------------------------

`timescale 1ns/1ps

module mem_server_ctrl (
  input  logic                   clk,
  input  logic                   rst,

  // Request queue head
  input  logic                   req_empty,
  input  mem_msg_pkg::mem_req_t  req_msg,
  output logic                   req_pop,

  // Response queue tail
  input  logic                   resp_full,
  output logic                   resp_push,
  output mem_msg_pkg::mem_resp_t resp_msg,

  // Word array access
  mem_port_if.ctrl               mem
);

  import mem_msg_pkg::*;

  typedef enum logic {
    st_issue,
    st_respond
  } state_e;

  state_e                   state;
  logic                     issue_go;
  // Request fields held for the response
  mem_op_e                  op_q;
  logic [mem_opaq_bits-1:0] opaque_q;
  logic [mem_addr_bits-1:0] addr_q;
  logic [mem_len_bits-1:0]  len_q;

  //----------------------------------------
  // Issue side
  //----------------------------------------

  // Need a request and room for its answer
  assign issue_go = (state == st_issue) && !req_empty && !resp_full;

  assign req_pop   = issue_go;
  assign mem.en    = issue_go;
  // Only a real write op touches memory
  assign mem.we    = issue_go && (req_msg.op == mem_op_write);
  assign mem.addr  = req_msg.addr;
  assign mem.len   = req_msg.len;
  assign mem.wdata = req_msg.data;

  // FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_issue;
    end else begin
      case (state)
        st_issue:   if (issue_go) state <= st_respond;
        st_respond: state <= st_issue;
        default:    state <= st_issue;
      endcase
    end
  end

  // Latch echo fields on the issue edge
  always_ff @(posedge clk) begin
    if (issue_go) begin
      op_q     <= req_msg.op;
      opaque_q <= req_msg.opaque;
      addr_q   <= req_msg.addr;
      len_q    <= req_msg.len;
    end
  end

  //----------------------------------------
  // Respond side
  //----------------------------------------

  // rdata lands during the respond cycle
  assign resp_push = (state == st_respond);

  always_comb begin
    resp_msg.op     = op_q;
    resp_msg.opaque = opaque_q;
    resp_msg.addr   = addr_q;
    resp_msg.len    = len_q;
    // Writes and undefined ops answer zero
    resp_msg.data   = (op_q == mem_op_read) ? mem.rdata : '0;
  end

  a_push_room: assert property (@(posedge clk) disable iff (rst) resp_push |-> !resp_full)
    else $error("mem_server_ctrl: push while response queue full");

endmodule

// File: verilog/msg_fifo.sv
//----------------------------------------
// Message FIFO
// Synchronous circular buffer, any payload
// type, head visible one cycle after push
//----------------------------------------

`timescale 1ns/1ps

module msg_fifo #(
  parameter type t_msg   = logic [7:0],
  parameter int  p_depth = 4
)(
  input  logic clk,
  input  logic rst,

  input  logic push,
  input  t_msg push_msg,
  input  logic pop,

  output logic full,
  output logic empty,
  output t_msg head_msg
);

  // Pointer width, at least one bit
  localparam int ptr_bits = (p_depth > 1) ? $clog2(p_depth) : 1;
  // Count runs 0 to p_depth inclusive
  localparam int cnt_bits = $clog2(p_depth + 1);

  t_msg                slots [p_depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                push_ok;
  logic                pop_ok;

  assign full  = (count == cnt_bits'(p_depth));
  assign empty = (count == '0);

  // Drop illegal strobes so pointers stay sane
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;

  assign head_msg = slots[rd_ptr];

  //----------------------------------------
  // Pointers and occupancy
  //----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok)
        wr_ptr <= (wr_ptr == ptr_bits'(p_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= (rd_ptr == ptr_bits'(p_depth - 1)) ? '0 : rd_ptr + 1'b1;
      // Simultaneous push and pop keeps the count
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (push_ok)
      slots[wr_ptr] <= push_msg;
  end

  // Senders must honour the flags
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("msg_fifo: push while full");
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
    else $error("msg_fifo: pop while empty");

endmodule
